// File: sources.f
src/snoopPkg.sv
src/busEventDecode.sv
src/wramPortTracker.sv
src/vramAddrTracker.sv
src/paletteOamTracker.sv
src/shadowAddrMap.sv
src/shadowWriteReq.sv
src/busSnoopTop.sv
testbench/tbBusSnoop.sv

// File: src/busEventDecode.sv
`timescale 1ns/10ps

module busEventDecode import snoopPkg::*; (
  input  logic       clkin,
  input  logic       reset,
  input  snesAddrT   snesAddr,
  input  ppuPortT    snesPa,
  input  snesByteT   snesData,
  input  logic       rdEnd,
  input  logic       wrEnd,
  input  logic       pardEnd,
  input  logic       pawrEnd,
  output snoopEventT snoopEvent
);

  // --------------------------------------------------
  // strobe kind and window
  // --------------------------------------------------

  // banks $00-$3F/$80-$BF, offsets $0000-$1FFF
  logic shadowWin;
  // banks $7E-$7F
  logic bankWin;

  assign shadowWin = !snesAddr[22] && (snesAddr[15:13] == 3'd0);
  assign bankWin   = (snesAddr[23:17] == 7'h3F);

  always_comb begin
    snoopEvent.addr = snesAddr;
    snoopEvent.data = snesData;
    // at most one strobe per cycle, order is only a tie-break
    if (rdEnd) snoopEvent.kind = evRd;
    else if (wrEnd) snoopEvent.kind = evWr;
    else if (pardEnd) snoopEvent.kind = evPaRd;
    else if (pawrEnd) snoopEvent.kind = evPaWr;
    else snoopEvent.kind = evNone;
    // window only for cpu writes
    if (wrEnd && shadowWin) snoopEvent.win = winShadow;
    else if (wrEnd && bankWin) snoopEvent.win = winBank;
    else snoopEvent.win = winNone;
  end

  // --------------------------------------------------
  // port number to register opcode
  // --------------------------------------------------
  always_comb begin
    snoopEvent.ppuReg = regNone;
    if (pawrEnd) begin
      case (snesPa)
        portVmain:   snoopEvent.ppuReg = regVmain;
        portVaddrL:  snoopEvent.ppuReg = regVaddrL;
        portVaddrH:  snoopEvent.ppuReg = regVaddrH;
        portVdataL:  snoopEvent.ppuReg = regVdataL;
        portVdataH:  snoopEvent.ppuReg = regVdataH;
        portCgAdd:   snoopEvent.ppuReg = regCgAdd;
        portCgData:  snoopEvent.ppuReg = regCgData;
        portOamAddL: snoopEvent.ppuReg = regOamAddL;
        portOamAddH: snoopEvent.ppuReg = regOamAddH;
        portOamData: snoopEvent.ppuReg = regOamData;
        portWmData:  snoopEvent.ppuReg = regWmData;
        portWmAddL:  snoopEvent.ppuReg = regWmAddL;
        portWmAddM:  snoopEvent.ppuReg = regWmAddM;
        portWmAddH:  snoopEvent.ppuReg = regWmAddH;
        default:     snoopEvent.ppuReg = regNone;
      endcase
    end else if (pardEnd) begin
      // reads that move a counter
      case (snesPa)
        portVreadL:  snoopEvent.ppuReg = regVreadL;
        portVreadH:  snoopEvent.ppuReg = regVreadH;
        portCgRead:  snoopEvent.ppuReg = regCgRead;
        portOamRead: snoopEvent.ppuReg = regOamRead;
        portWmData:  snoopEvent.ppuReg = regWmData;
        default:     snoopEvent.ppuReg = regNone;
      endcase
    end
  end

  // strobes from the bus are mutually exclusive
  strobeOneHot: assert property (@(posedge clkin) disable iff (reset)
    $onehot0({rdEnd, wrEnd, pardEnd, pawrEnd}));

endmodule

// File: src/busSnoopTop.sv
`timescale 1ns/10ps

module busSnoopTop import snoopPkg::*; #(
  parameter snesAddrT wramBase = 24'hF50000,
  parameter snesAddrT vramBase = 24'hF70000,
  parameter snesAddrT palBase  = 24'hF90000,
  parameter snesAddrT oamBase  = 24'hF90200
) (
  input  logic     clkin,
  input  logic     reset,
  input  snesAddrT snesAddr,
  input  ppuPortT  snesPa,
  input  snesByteT snesData,
  input  logic     rdEnd,
  input  logic     wrEnd,
  input  logic     pardEnd,
  input  logic     pawrEnd,
  input  logic     busRdy,
  output logic     busWrq,
  output snesAddrT shadowAddr,
  output snesByteT shadowData
);

  // --------------------------------------------------
  // internal nets
  // --------------------------------------------------
  snoopEventT  snoopEvent;
  snesAddrT    wramPortAddr;
  logic [15:0] vramAddr;
  vramRemapE   vramRemap;
  logic [8:0]  cgramAddr;
  logic [9:0]  oamAddr;
  logic        writeHit;
  shadowReqT   req;

  // input side
  busEventDecode busEventDecode_i (.*);

  // trackers
  wramPortTracker wramPortTracker_i (.*);
  vramAddrTracker vramAddrTracker_i (.*);
  paletteOamTracker paletteOamTracker_i (.*);

  // map uses tracker values from before the edge
  shadowAddrMap #(
    .wramBase(wramBase),
    .vramBase(vramBase),
    .palBase (palBase),
    .oamBase (oamBase)
  ) shadowAddrMap_i (.*);

  // output side
  shadowWriteReq shadowWriteReq_i (.*);

endmodule

// File: src/paletteOamTracker.sv
`timescale 1ns/10ps

module paletteOamTracker import snoopPkg::*; (
  input  logic       clkin,
  input  logic       reset,
  input  snoopEventT snoopEvent,
  output logic [8:0] cgramAddr,
  output logic [9:0] oamAddr
);

  // --------------------------------------------------
  // cgram byte address
  // --------------------------------------------------

  // word address in, byte address kept
  always_ff @(posedge clkin) begin
    if (reset) begin
      cgramAddr <= '0;
    end else begin
      case (snoopEvent.ppuReg)
        regCgAdd:  cgramAddr <= {snoopEvent.data, 1'b0};
        // write and read share the counter
        regCgData,
        regCgRead: cgramAddr <= cgramAddr + 9'd1;
        default: begin
          // hold
        end
      endcase
    end
  end

  // --------------------------------------------------
  // oam byte address
  // --------------------------------------------------

  // bit 9 selects the 32-byte high table
  always_ff @(posedge clkin) begin
    if (reset) begin
      oamAddr <= '0;
    end else begin
      case (snoopEvent.ppuReg)
        // low write keeps table select
        regOamAddL: oamAddr <= {oamAddr[9], snoopEvent.data, 1'b0};
        // high write only takes data bit 0
        regOamAddH: oamAddr <= {snoopEvent.data[0], oamAddr[8:1], 1'b0};
        regOamData,
        regOamRead: oamAddr <= oamAddr + 10'd1;
        default: begin
          // hold
        end
      endcase
    end
  end

endmodule

// File: src/shadowAddrMap.sv
`timescale 1ns/10ps

module shadowAddrMap import snoopPkg::*; #(
  parameter snesAddrT wramBase = 24'hF50000,
  parameter snesAddrT vramBase = 24'hF70000,
  parameter snesAddrT palBase  = 24'hF90000,
  parameter snesAddrT oamBase  = 24'hF90200
) (
  input  snoopEventT  snoopEvent,
  input  snesAddrT    wramPortAddr,
  input  logic [15:0] vramAddr,
  input  vramRemapE   vramRemap,
  input  logic [8:0]  cgramAddr,
  input  logic [9:0]  oamAddr,
  output logic        writeHit,
  output shadowReqT   req
);

  // --------------------------------------------------
  // address helpers
  // --------------------------------------------------

  // remapped vram word, bit 15 dropped
  logic [14:0] vramWord;
  // high table wraps at 32 bytes
  logic [9:0]  oamEff;
  logic        highPort;

  always_comb begin
    case (vramRemap)
      remapNone: vramWord = vramAddr[14:0];
      remap8:    vramWord = {vramAddr[14:8], vramAddr[4:0], vramAddr[7:5]};
      remap9:    vramWord = {vramAddr[14:9], vramAddr[5:0], vramAddr[8:6]};
      default:   vramWord = {vramAddr[14:10], vramAddr[6:0], vramAddr[9:7]};
    endcase
  end

  assign oamEff   = oamAddr[9] ? (oamAddr & 10'h21F) : oamAddr;
  assign highPort = (snoopEvent.ppuReg == regVdataH);

  // --------------------------------------------------
  // target select
  // --------------------------------------------------
  always_comb begin
    writeHit = 1'b0;
    req.addr = '0;
    // always the bus byte
    req.data = snoopEvent.data;
    if (snoopEvent.kind == evWr) begin
      case (snoopEvent.win)
        winShadow: begin
          writeHit = 1'b1;
          req.addr = wramBase + {11'd0, snoopEvent.addr[12:0]};
        end
        winBank: begin
          writeHit = 1'b1;
          req.addr = wramBase + {7'd0, snoopEvent.addr[16:0]};
        end
        default: writeHit = 1'b0;
      endcase
    end else if (snoopEvent.kind == evPaWr) begin
      case (snoopEvent.ppuReg)
        regWmData: begin
          writeHit = 1'b1;
          req.addr = wramBase + {7'd0, wramPortAddr[16:0]};
        end
        // word address times two, high port odd
        regVdataL, regVdataH: begin
          writeHit = 1'b1;
          req.addr = vramBase + {8'd0, vramWord, highPort};
        end
        regCgData: begin
          writeHit = 1'b1;
          req.addr = palBase + {15'd0, cgramAddr};
        end
        regOamData: begin
          writeHit = 1'b1;
          req.addr = oamBase + {14'd0, oamEff};
        end
        default: writeHit = 1'b0;
      endcase
    end
  end

endmodule

// File: src/shadowWriteReq.sv
`timescale 1ns/10ps

module shadowWriteReq import snoopPkg::*; (
  input  logic      clkin,
  input  logic      reset,
  input  logic      writeHit,
  input  shadowReqT req,
  input  logic      busRdy,
  output logic      busWrq,
  output snesAddrT  shadowAddr,
  output snesByteT  shadowData
);

  // --------------------------------------------------
  // one-deep request slot
  // --------------------------------------------------
  logic pending;

  // newest write wins over a pending one
  always_ff @(posedge clkin) begin
    if (reset) begin
      pending <= 1'b0;
    end else if (writeHit) begin
      pending <= 1'b1;
    end else if (pending && busRdy) begin
      pending <= 1'b0;
    end
  end

  // payload
  always_ff @(posedge clkin) begin
    if (writeHit) begin
      shadowAddr <= req.addr;
      shadowData <= req.data;
    end
  end

  // released for one cycle once ready is seen
  assign busWrq = pending && busRdy;

  // held request must not move under back-pressure
  holdStable: assert property (@(posedge clkin) disable iff (reset)
    (pending && !busRdy && !writeHit) |=> ($stable(shadowAddr) && $stable(shadowData)));

endmodule

// File: src/snoopPkg.sv
package snoopPkg;

  // --------------------------------------------------
  // basic bus types
  // --------------------------------------------------

  // cpu bus address, also used for shadow addresses
  typedef logic [23:0] snesAddrT;
  typedef logic [7:0]  snesByteT;
  // low byte of a $21xx access
  typedef logic [7:0]  ppuPortT;

  // strobe seen in the current cycle
  typedef enum logic [2:0] {
    evNone, evRd, evWr, evPaRd, evPaWr
  } busKindE;

  // peripheral register opcode, read and write ports kept apart
  typedef enum logic [4:0] {
    regNone,
    regVmain, regVaddrL, regVaddrH, regVdataL, regVdataH, regVreadL, regVreadH,
    regCgAdd, regCgData, regCgRead,
    regOamAddL, regOamAddH, regOamData, regOamRead,
    regWmData, regWmAddL, regWmAddM, regWmAddH
  } ppuRegE;

  // direct wram windows of the cpu bus
  typedef enum logic [1:0] {
    winNone, winShadow, winBank
  } wramWinE;

  // one decoded bus event, 42 bits
  typedef struct packed {
    busKindE  kind;
    ppuRegE   ppuReg;
    wramWinE  win;
    snesAddrT addr;
    snesByteT data;
  } snoopEventT;

  // vram address remap, control bits 3:2
  typedef enum logic [1:0] {
    remapNone, remap8, remap9, remap10
  } vramRemapE;

  // one byte for the external memory bus
  typedef struct packed {
    snesAddrT addr;
    snesByteT data;
  } shadowReqT;

  // --------------------------------------------------
  // $21xx port numbers
  // --------------------------------------------------
  localparam ppuPortT portOamAddL = 8'h02;
  localparam ppuPortT portOamAddH = 8'h03;
  localparam ppuPortT portOamData = 8'h04;
  localparam ppuPortT portVmain   = 8'h15;
  localparam ppuPortT portVaddrL  = 8'h16;
  localparam ppuPortT portVaddrH  = 8'h17;
  localparam ppuPortT portVdataL  = 8'h18;
  localparam ppuPortT portVdataH  = 8'h19;
  localparam ppuPortT portCgAdd   = 8'h21;
  localparam ppuPortT portCgData  = 8'h22;
  // read-only ports
  localparam ppuPortT portOamRead = 8'h38;
  localparam ppuPortT portVreadL  = 8'h39;
  localparam ppuPortT portVreadH  = 8'h3A;
  localparam ppuPortT portCgRead  = 8'h3B;
  // wram port, data is read/write
  localparam ppuPortT portWmData  = 8'h80;
  localparam ppuPortT portWmAddL  = 8'h81;
  localparam ppuPortT portWmAddM  = 8'h82;
  localparam ppuPortT portWmAddH  = 8'h83;

endpackage

// File: src/vramAddrTracker.sv
`timescale 1ns/10ps

module vramAddrTracker import snoopPkg::*; (
  input  logic        clkin,
  input  logic        reset,
  input  snoopEventT  snoopEvent,
  output logic [15:0] vramAddr,
  output vramRemapE   vramRemap
);

  // --------------------------------------------------
  // $2115 control and step size
  // --------------------------------------------------

  // bit 7 inc on high port, 3:2 remap, 1:0 step
  logic [7:0]  vmain;
  logic [15:0] step;
  logic        lowHit;
  logic        highHit;
  logic        incHit;

  always_comb begin
    case (vmain[1:0])
      2'b00:   step = 16'd1;
      2'b01:   step = 16'd32;
      // 10 and 11 both step 128
      default: step = 16'd128;
    endcase
  end

  // data writes and prefetch reads both count
  assign lowHit  = (snoopEvent.ppuReg == regVdataL) || (snoopEvent.ppuReg == regVreadL);
  assign highHit = (snoopEvent.ppuReg == regVdataH) || (snoopEvent.ppuReg == regVreadH);
  assign incHit  = vmain[7] ? highHit : lowHit;

  assign vramRemap = vramRemapE'(vmain[3:2]);

  // --------------------------------------------------
  // word address register
  // --------------------------------------------------
  always_ff @(posedge clkin) begin
    if (reset) begin
      vmain    <= '0;
      vramAddr <= '0;
    end else begin
      case (snoopEvent.ppuReg)
        regVmain:  vmain          <= snoopEvent.data;
        regVaddrL: vramAddr[7:0]  <= snoopEvent.data;
        regVaddrH: vramAddr[15:8] <= snoopEvent.data;
        default: begin
          // port selected by vmain[7]
          if (incHit) begin
            vramAddr <= vramAddr + step;
          end
        end
      endcase
    end
  end

  // an increment moves the word address by 1, 32 or 128
  stepLegal: assert property (@(posedge clkin) disable iff (reset)
    incHit |=> ((vramAddr - $past(vramAddr)) inside {16'd1, 16'd32, 16'd128}));

endmodule

// File: src/wramPortTracker.sv
`timescale 1ns/10ps

module wramPortTracker import snoopPkg::*; (
  input  logic       clkin,
  input  logic       reset,
  input  snoopEventT snoopEvent,
  output snesAddrT   wramPortAddr
);

  // --------------------------------------------------
  // $2181-$2183 address, $2180 auto-increment
  // --------------------------------------------------

  // only 17 bits wrap on increment
  logic [16:0] nextLow;

  assign nextLow = wramPortAddr[16:0] + 17'd1;

  always_ff @(posedge clkin) begin
    if (reset) begin
      wramPortAddr <= '0;
    end else begin
      case (snoopEvent.ppuReg)
        // byte loads
        regWmAddL: wramPortAddr[7:0]   <= snoopEvent.data;
        regWmAddM: wramPortAddr[15:8]  <= snoopEvent.data;
        regWmAddH: wramPortAddr[23:16] <= snoopEvent.data;
        // read or write of the data port
        regWmData: wramPortAddr[16:0]  <= nextLow;
        default: begin
          // other registers leave it alone
        end
      endcase
    end
  end

endmodule

// File: testbench/tbBusSnoop.sv
`timescale 1ns/10ps

module tbBusSnoop import snoopPkg::*; ();

  // same defaults as busSnoopTop
  localparam snesAddrT wramBase = 24'hF50000;
  localparam snesAddrT vramBase = 24'hF70000;
  localparam snesAddrT palBase  = 24'hF90000;
  localparam snesAddrT oamBase  = 24'hF90200;

  // one table row with its hand-worked expectation
  typedef struct packed {
    busKindE    kind;
    snesAddrT   addr;
    snesByteT   data;
    logic [3:0] holdOff;
    logic       expReq;
    snesAddrT   expAddr;
    snesByteT   expData;
  } stimT;

  logic     clkin;
  logic     reset;
  snesAddrT snesAddr;
  ppuPortT  snesPa;
  snesByteT snesData;
  logic     rdEnd;
  logic     wrEnd;
  logic     pardEnd;
  logic     pawrEnd;
  logic     busRdy;
  logic     busWrq;
  snesAddrT shadowAddr;
  snesByteT shadowData;

  stimT        stimQ[$];
  int          errCount;
  logic [15:0] lfsrState;

  busSnoopTop dut_i (.*);

  always #5 clkin = ~clkin;

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // one lfsr step per bit
  task automatic drawBits(input int n, output logic [23:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrStep(lfsrState);
      val = {val[22:0], lfsrState[0]};
    end
  endtask

  // noise on the lines while no strobe is up
  task automatic randomizeIdle();
    logic [23:0] v;
    drawBits(24, v);
    snesAddr = v;
    drawBits(8, v);
    snesPa = v[7:0];
    drawBits(8, v);
    snesData = v[7:0];
  endtask

  task automatic checkAddr(input string name, input snesAddrT got, input snesAddrT exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
      errCount++;
    end
  endtask

  task automatic checkData(input string name, input snesByteT got, input snesByteT exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
      errCount++;
    end
  endtask

  task automatic addEntry(input busKindE kind, input snesAddrT addr, input snesByteT data,
                          input int holdOff, input logic expReq, input snesAddrT expAddr,
                          input snesByteT expData);
    stimQ.push_back('{kind, addr, data, holdOff[3:0], expReq, expAddr, expData});
  endtask

  // --------------------------------------------------
  // stimulus table
  // --------------------------------------------------
  task automatic fillTable();
    // direct windows then a plain cpu read
    addEntry(evWr,   24'h001234, 8'hA5, 0, 1, wramBase + 24'h001234, 8'hA5);
    addEntry(evWr,   24'h7F8765, 8'h3C, 0, 1, wramBase + 24'h018765, 8'h3C);
    addEntry(evRd,   24'h001234, 8'h00, 0, 0, '0, '0);
    // wram port at $012010
    addEntry(evPaWr, 24'h002181, 8'h10, 0, 0, '0, '0);
    addEntry(evPaWr, 24'h002182, 8'h20, 0, 0, '0, '0);
    addEntry(evPaWr, 24'h002183, 8'h01, 0, 0, '0, '0);
    addEntry(evPaWr, 24'h002180, 8'h11, 0, 1, wramBase + 24'h012010, 8'h11);
    addEntry(evPaWr, 24'h002180, 8'h22, 0, 1, wramBase + 24'h012011, 8'h22);
    // read skips one location
    addEntry(evPaRd, 24'h002180, 8'h00, 0, 0, '0, '0);
    addEntry(evPaWr, 24'h002180, 8'h33, 0, 1, wramBase + 24'h012013, 8'h33);
    // vram step 32 on high port, word $1000
    addEntry(evPaWr, 24'h002115, 8'h81, 0, 0, '0, '0);
    addEntry(evPaWr, 24'h002116, 8'h00, 0, 0, '0, '0);
    addEntry(evPaWr, 24'h002117, 8'h10, 0, 0, '0, '0);
    addEntry(evPaWr, 24'h002118, 8'h44, 0, 1, vramBase + 24'h002000, 8'h44);
    addEntry(evPaWr, 24'h002119, 8'h55, 0, 1, vramBase + 24'h002001, 8'h55);
    addEntry(evPaWr, 24'h002118, 8'h66, 0, 1, vramBase + 24'h002040, 8'h66);
    addEntry(evPaWr, 24'h002119, 8'h77, 0, 1, vramBase + 24'h002041, 8'h77);
    // remap8 at word $1040 gives $1002
    addEntry(evPaWr, 24'h002115, 8'h84, 0, 0, '0, '0);
    addEntry(evPaWr, 24'h002118, 8'h88, 0, 1, vramBase + 24'h002004, 8'h88);
    // palette word 5 is byte $0A
    addEntry(evPaWr, 24'h002121, 8'h05, 0, 0, '0, '0);
    addEntry(evPaWr, 24'h002122, 8'h99, 0, 1, palBase + 24'h00000A, 8'h99);
    addEntry(evPaWr, 24'h002122, 8'h9A, 0, 1, palBase + 24'h00000B, 8'h9A);
    // palette read moves the counter past $0C
    addEntry(evPaRd, 24'h00213B, 8'h00, 0, 0, '0, '0);
    addEntry(evPaWr, 24'h002122, 8'h9B, 0, 1, palBase + 24'h00000D, 8'h9B);
    // oam high table masks $226 to $206
    addEntry(evPaWr, 24'h002103, 8'h01, 0, 0, '0, '0);
    addEntry(evPaWr, 24'h002102, 8'h13, 0, 0, '0, '0);
    addEntry(evPaWr, 24'h002104, 8'hBB, 0, 1, oamBase + 24'h000206, 8'hBB);
    // held back by busRdy
    addEntry(evWr,   24'h000010, 8'h5A, 5, 1, wramBase + 24'h000010, 8'h5A);
    // unmapped write and a read of a write-only port
    addEntry(evPaWr, 24'h002140, 8'hFF, 0, 0, '0, '0);
    addEntry(evPaRd, 24'h002118, 8'h00, 0, 0, '0, '0);
  endtask

  // --------------------------------------------------
  // one strobe per entry
  // --------------------------------------------------
  task automatic applyEntry(input stimT e, input int idx);
    int errBefore;
    int waitCnt;
    errBefore = errCount;
    @(posedge clkin);
    #1;
    snesAddr = e.addr;
    snesPa   = e.addr[7:0];
    snesData = e.data;
    busRdy   = (e.holdOff == 0);
    case (e.kind)
      evRd:    rdEnd   = 1'b1;
      evWr:    wrEnd   = 1'b1;
      evPaRd:  pardEnd = 1'b1;
      evPaWr:  pawrEnd = 1'b1;
      default: rdEnd   = 1'b0;
    endcase
    @(posedge clkin);
    #1;
    rdEnd   = 1'b0;
    wrEnd   = 1'b0;
    pardEnd = 1'b0;
    pawrEnd = 1'b0;
    randomizeIdle();
    if (e.expReq) begin
      // outputs must sit still while held
      repeat (e.holdOff) begin
        @(negedge clkin);
        if (busWrq) begin
          $display("t=%0t busWrq went high while busRdy was low", $time);
          errCount++;
        end
        checkAddr("shadowAddr", shadowAddr, e.expAddr);
        checkData("shadowData", shadowData, e.expData);
      end
      if (e.holdOff != 0) begin
        @(posedge clkin);
        #1;
        busRdy = 1'b1;
      end
      waitCnt = 0;
      @(negedge clkin);
      while (!busWrq && waitCnt < 10) begin
        @(negedge clkin);
        waitCnt++;
      end
      if (!busWrq) begin
        $display("t=%0t no request seen for entry %0d", $time, idx);
        errCount++;
      end else begin
        // request is due in the first cycle with busRdy high
        if (waitCnt != 0) begin
          $display("t=%0t busWrq came %0d cycles late for entry %0d", $time, waitCnt, idx);
          errCount++;
        end
        checkAddr("shadowAddr", shadowAddr, e.expAddr);
        checkData("shadowData", shadowData, e.expData);
        // single cycle release
        @(negedge clkin);
        if (busWrq) begin
          $display("t=%0t busWrq stayed high for more than one cycle", $time);
          errCount++;
        end
      end
    end else begin
      repeat (3) begin
        @(negedge clkin);
        if (busWrq) begin
          $display("t=%0t unexpected request for entry %0d", $time, idx);
          errCount++;
        end
      end
    end
    $display("entry %0d %s", idx, (errCount == errBefore) ? "ok" : "FAILED");
  endtask

  // --------------------------------------------------
  // main sequence and watchdog
  // --------------------------------------------------
  initial begin
    clkin     = 1'b0;
    reset     = 1'b1;
    snesAddr  = '0;
    snesPa    = '0;
    snesData  = '0;
    rdEnd     = 1'b0;
    wrEnd     = 1'b0;
    pardEnd   = 1'b0;
    pawrEnd   = 1'b0;
    busRdy    = 1'b1;
    errCount  = 0;
    lfsrState = 16'd61985;
    fillTable();
    repeat (8) @(posedge clkin);
    #1;
    reset = 1'b0;
    for (int i = 0; i < stimQ.size(); i++) begin
      applyEntry(stimQ[i], i);
    end
    $display("%0d entries run, %0d errors", stimQ.size(), errCount);
    if (errCount == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // 40 cycles per entry plus reset
  initial begin
    #1;
    repeat (stimQ.size() * 40 + 8) @(posedge clkin);
    $display("watchdog expired before the table finished");
    $display("TEST FAIL");
    $finish;
  end

endmodule
